/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // data path width, fixed for RV32I
  localparam int xlen = 32;

  // major opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    // register-register arithmetic
    OPC_OP     = 7'b0110011,
    // register-immediate arithmetic
    OPC_OP_IMM = 7'b0010011,
    // word load only
    OPC_LOAD   = 7'b0000011,
    // word store only
    OPC_STORE  = 7'b0100011,
    // beq and bne
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // second operand straight through, used by lui
    ALU_PASS_B = 4'd10
  } alu_op_t;

  // first alu operand source
  typedef enum logic [1:0] {
    SRC_A_PC   = 2'd0,
    SRC_A_ZERO = 2'd1,
    SRC_A_RS1  = 2'd2
  } src_a_t;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU      = 2'd0,
    WB_MEM      = 2'd1,
    WB_PC_PLUS4 = 2'd2
  } wb_sel_t;

  // branch funct3 codes
  localparam logic [2:0] FUNCT3_BEQ = 3'b000;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;

endpackage

`default_nettype wire

/* alu/alu.sv */
`default_nettype none
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         op,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    zero
);

  import rv_pkg::*;

  // shift amount from the low five bits
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      // set-less-than gives 0 or 1
      ALU_SLT:    result = {{(xlen-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      // sign fill from bit 31
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      // lui immediate straight through
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // equal compare for branches when op is sub
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
  input  logic [rv_pkg::xlen-1:0] idata,
  output logic                    reg_write,
  output logic                    mem_write,
  output logic                    branch,
  output logic                    jump,
  output logic                    alu_src_b,
  output rv_pkg::src_a_t          src_a,
  output rv_pkg::wb_sel_t         wb_sel,
  output rv_pkg::alu_op_t         alu_op
);

  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  // funct7 bit 5, selects sub and arithmetic shift
  logic       bit30;

  assign opcode = opcode_t'(idata[6:0]);
  assign funct3 = idata[14:12];
  assign bit30  = idata[30];

  // arithmetic op from funct3, bit 30 only counts for sub when register form
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                       input logic is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      // srl/sra and srli/srai share funct3
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // safe defaults, no writes for unknown opcodes
    reg_write = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    alu_src_b = 1'b0;
    src_a     = SRC_A_RS1;
    wb_sel    = WB_ALU;
    alu_op    = ALU_ADD;
    case (opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        alu_op    = arith_op(funct3, bit30, 1'b1);
      end
      OPC_OP_IMM: begin
        reg_write = 1'b1;
        alu_src_b = 1'b1;
        alu_op    = arith_op(funct3, bit30, 1'b0);
      end
      OPC_LOAD: begin
        // address is rs1 + imm
        reg_write = 1'b1;
        alu_src_b = 1'b1;
        wb_sel    = WB_MEM;
      end
      OPC_STORE: begin
        mem_write = 1'b1;
        alu_src_b = 1'b1;
      end
      OPC_BRANCH: begin
        // rs1 - rs2, zero flag means equal
        branch = 1'b1;
        alu_op = ALU_SUB;
      end
      OPC_JAL: begin
        // link value, target comes from the pc unit
        reg_write = 1'b1;
        jump      = 1'b1;
        wb_sel    = WB_PC_PLUS4;
      end
      OPC_LUI: begin
        reg_write = 1'b1;
        alu_src_b = 1'b1;
        src_a     = SRC_A_ZERO;
        alu_op    = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        // pc of this word plus upper immediate
        reg_write = 1'b1;
        alu_src_b = 1'b1;
        src_a     = SRC_A_PC;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_pkg::xlen-1:0] idata,
  output logic [rv_pkg::xlen-1:0] imm
);

  import rv_pkg::*;

  opcode_t opcode;
  // sign bit of every format
  logic    sgn;

  assign opcode = opcode_t'(idata[6:0]);
  assign sgn    = idata[31];

  always_comb begin
    case (opcode)
      // s format, split across funct7 and rd fields
      OPC_STORE: begin
        imm = {{(xlen-12){sgn}}, idata[31:25], idata[11:7]};
      end
      // b format, bit 0 always zero
      OPC_BRANCH: begin
        imm = {{(xlen-12){sgn}}, idata[7], idata[30:25], idata[11:8], 1'b0};
      end
      // u format, upper twenty bits
      OPC_LUI, OPC_AUIPC: begin
        imm = {idata[31:12], 12'b0};
      end
      // j format, bit 0 always zero
      OPC_JAL: begin
        imm = {{(xlen-20){sgn}}, idata[19:12], idata[20], idata[30:21], 1'b0};
      end
      // i format for op-imm and load
      // also the fallback, register ops ignore it
      default: begin
        imm = {{(xlen-12){sgn}}, idata[31:20]};
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  logic                    CLK,
  input  logic                    RESET_N,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  input  logic [4:0]              rd_addr,
  input  logic                    wr_en,
  input  logic [rv_pkg::xlen-1:0] wr_data,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data
);

  import rv_pkg::*;

  // x0 .. x31
  logic [xlen-1:0] regs [32];
  // x0 never takes a write
  logic            wr_ok;

  assign wr_ok = wr_en && (rd_addr != 5'd0);

  // write at the end of the instruction cycle
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[rd_addr] <= wr_data;
    end
  end

  // combinational read ports
  // a value written at an edge shows up right after it
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module execute_unit #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic [ADDR_WIDTH-1:0]   pc,
  input  logic [ADDR_WIDTH-1:0]   pc_plus4,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] ddata_r,
  input  rv_pkg::src_a_t          src_a,
  input  logic                    alu_src_b,
  input  rv_pkg::alu_op_t         alu_op,
  input  rv_pkg::wb_sel_t         wb_sel,
  output logic [rv_pkg::xlen-1:0] alu_result,
  output logic [rv_pkg::xlen-1:0] wr_data,
  output logic                    alu_zero
);

  import rv_pkg::*;

  // pc values widened to the data path, zero filled
  logic [xlen-1:0] pc_ext;
  logic [xlen-1:0] pc_plus4_ext;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  assign pc_ext       = xlen'(pc);
  assign pc_plus4_ext = xlen'(pc_plus4);

  // first operand, pc for auipc and zero for lui
  always_comb begin
    case (src_a)
      SRC_A_PC:   op_a = pc_ext;
      SRC_A_ZERO: op_a = '0;
      default:    op_a = rs1_data;
    endcase
  end

  // second operand, immediate or rs2
  assign op_b = alu_src_b ? imm : rs2_data;

  alu u_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // register write-back value
  always_comb begin
    case (wb_sel)
      WB_MEM:      wr_data = ddata_r;
      // jal link address
      WB_PC_PLUS4: wr_data = pc_plus4_ext;
      default:     wr_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/pc_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module pc_unit #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                    CLK,
  input  logic                    RESET_N,
  input  logic                    branch,
  input  logic                    jump,
  input  logic                    alu_zero,
  input  logic [2:0]              funct3,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [ADDR_WIDTH-1:0]   pc,
  output logic [ADDR_WIDTH-1:0]   pc_plus4
);

  import rv_pkg::*;

  logic [ADDR_WIDTH-1:0] target;
  logic [ADDR_WIDTH-1:0] pc_next;
  // high when the target is taken this cycle
  logic                  taken;

  // sequential and relative target adders
  assign pc_plus4 = pc + ADDR_WIDTH'(4);
  // immediate truncated to the pc width
  assign target   = pc + ADDR_WIDTH'(imm);

  always_comb begin
    taken = 1'b0;
    if (jump) begin
      taken = 1'b1;
    end else if (branch) begin
      case (funct3)
        FUNCT3_BEQ: taken = alu_zero;
        FUNCT3_BNE: taken = !alu_zero;
        // other branch types not supported
        default:    taken = 1'b0;
      endcase
    end
  end

  assign pc_next = taken ? target : pc_plus4;

  // byte address of the current word
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                    CLK,
  input  logic                    RESET_N,
  input  logic [rv_pkg::xlen-1:0] idata,
  output logic [ADDR_WIDTH-1:0]   iaddr,
  output logic [ADDR_WIDTH-1:0]   daddr,
  input  logic [rv_pkg::xlen-1:0] ddata_r,
  output logic [rv_pkg::xlen-1:0] ddata_w,
  output logic                    d_rw
);

  import rv_pkg::*;

  // register indices straight out of the fetched word
  logic [4:0]            rs1_addr;
  logic [4:0]            rs2_addr;
  logic [4:0]            rd_addr;
  logic [2:0]            funct3;

  // control levels
  logic                  reg_write;
  logic                  mem_write;
  logic                  branch;
  logic                  jump;
  logic                  alu_src_b;
  src_a_t                src_a;
  wb_sel_t               wb_sel;
  alu_op_t               alu_op;

  // data path
  logic [xlen-1:0]       imm;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       wr_data;
  logic [xlen-1:0]       alu_result;
  logic                  alu_zero;
  logic [ADDR_WIDTH-1:0] pc;
  logic [ADDR_WIDTH-1:0] pc_plus4;

  assign rs1_addr = idata[19:15];
  assign rs2_addr = idata[24:20];
  assign rd_addr  = idata[11:7];
  assign funct3   = idata[14:12];

  // byte addresses down to word addresses
  assign iaddr   = pc >> 2;
  assign daddr   = ADDR_WIDTH'(alu_result >> 2);
  // store data is always rs2
  assign ddata_w = rs2_data;
  assign d_rw    = mem_write;

  instr_decoder u_decoder (
    .idata     (idata),
    .reg_write (reg_write),
    .mem_write (mem_write),
    .branch    (branch),
    .jump      (jump),
    .alu_src_b (alu_src_b),
    .src_a     (src_a),
    .wb_sel    (wb_sel),
    .alu_op    (alu_op)
  );

  // runs beside the decoder on the same word
  imm_gen u_imm_gen (
    .idata (idata),
    .imm   (imm)
  );

  reg_file u_reg_file (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .wr_en    (reg_write),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_execute (
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .ddata_r    (ddata_r),
    .src_a      (src_a),
    .alu_src_b  (alu_src_b),
    .alu_op     (alu_op),
    .wb_sel     (wb_sel),
    .alu_result (alu_result),
    .wr_data    (wr_data),
    .alu_zero   (alu_zero)
  );

  pc_unit #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_pc_unit (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .branch   (branch),
    .jump     (jump),
    .alu_zero (alu_zero),
    .funct3   (funct3),
    .imm      (imm),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

endmodule

`default_nettype wire

/* verification/rv_core_props.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core_props #(
  parameter int ADDR_WIDTH = 10
) (
  input logic                    CLK,
  input logic                    RESET_N,
  input logic [ADDR_WIDTH-1:0]   iaddr,
  input logic [ADDR_WIDTH-1:0]   pc,
  input logic [4:0]              rs1_addr,
  input logic [4:0]              rs2_addr,
  input logic [4:0]              rd_addr,
  input logic [rv_pkg::xlen-1:0] rs1_data,
  input logic [rv_pkg::xlen-1:0] rs2_data,
  input logic                    reg_write,
  input logic [rv_pkg::xlen-1:0] wr_data,
  input logic [rv_pkg::xlen-1:0] ddata_w,
  input logic                    d_rw,
  input logic                    branch,
  input logic [2:0]              funct3,
  input logic [rv_pkg::xlen-1:0] imm
);

  import rv_pkg::*;

  // beq on equal, bne on not equal, decided from the register operands
  logic                  taken_branch;
  logic                  operands_equal;
  logic [ADDR_WIDTH-1:0] branch_target;
  // architectural register values rebuilt from the write-back stream
  logic [xlen-1:0]       shadow [32];

  assign operands_equal = (rs1_data == rs2_data);
  assign taken_branch   = branch && (((funct3 == FUNCT3_BEQ) && operands_equal) ||
                                     ((funct3 == FUNCT3_BNE) && !operands_equal));
  assign branch_target  = pc + ADDR_WIDTH'(imm);

  // x0 keeps its reset value
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] <= '0;
      end
    end else if (reg_write && (rd_addr != 5'd0)) begin
      shadow[rd_addr] <= wr_data;
    end
  end

  // x0 reads zero on both ports
  a_x0_rs1 : assert property (@(posedge CLK) disable iff (!RESET_N)
    (rs1_addr == 5'd0) |-> (rs1_data == '0))
    else $error("x0 read through rs1 is not zero");

  a_x0_rs2 : assert property (@(posedge CLK) disable iff (!RESET_N)
    (rs2_addr == 5'd0) |-> (rs2_data == '0))
    else $error("x0 read through rs2 is not zero");

  // fetch address always known once out of reset
  a_iaddr_known : assert property (@(posedge CLK) disable iff (!RESET_N)
    !$isunknown(iaddr))
    else $error("iaddr has unknown bits");

  // store data is the last value written to rs2
  a_store_data : assert property (@(posedge CLK) disable iff (!RESET_N)
    d_rw |-> (ddata_w == shadow[rs2_addr]))
    else $error("store data differs from rs2 data");

  // taken branch lands on its target one edge later
  a_branch_target : assert property (@(posedge CLK) disable iff (!RESET_N)
    taken_branch |=> (pc == $past(branch_target)))
    else $error("taken branch did not move the pc to its target");

endmodule

bind rv_core rv_core_props #(
  .ADDR_WIDTH (ADDR_WIDTH)
) u_props (
  .CLK       (CLK),
  .RESET_N   (RESET_N),
  .iaddr     (iaddr),
  .pc        (pc),
  .rs1_addr  (rs1_addr),
  .rs2_addr  (rs2_addr),
  .rd_addr   (rd_addr),
  .rs1_data  (rs1_data),
  .rs2_data  (rs2_data),
  .reg_write (reg_write),
  .wr_data   (wr_data),
  .ddata_w   (ddata_w),
  .d_rw      (d_rw),
  .branch    (branch),
  .funct3    (funct3),
  .imm       (imm)
);

`default_nettype wire

/* verification/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;

  import rv_pkg::*;

  localparam int  ADDR_WIDTH  = 10;
  localparam int  MEM_WORDS   = 1 << ADDR_WIDTH;
  localparam int  MAX_STORES  = 64;
  localparam time CLK_PERIOD  = 40ns;
  localparam time DRIVE_DELAY = 1ns;
  localparam      VECTOR_FILE = "verification/rv_core_vectors.txt";

  logic                  CLK;
  logic                  RESET_N;
  logic [xlen-1:0]       idata;
  logic [ADDR_WIDTH-1:0] iaddr;
  logic [ADDR_WIDTH-1:0] daddr;
  logic [xlen-1:0]       ddata_r;
  logic [xlen-1:0]       ddata_w;
  logic                  d_rw;

  // word-addressed instruction and data memories
  logic [xlen-1:0]       imem [MEM_WORDS];
  logic [xlen-1:0]       dmem [MEM_WORDS];
  // expected store sequence from E lines
  logic [ADDR_WIDTH-1:0] exp_addr [MAX_STORES];
  logic [xlen-1:0]       exp_data [MAX_STORES];

  int num_expected = 0;
  int num_checked  = 0;
  int num_errors   = 0;
  int prog_len     = 0;
  int cycle_limit  = 0;
  int cycles       = 0;

  rv_core #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) UUT (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .idata   (idata),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .ddata_r (ddata_r),
    .ddata_w (ddata_w),
    .d_rw    (d_rw)
  );

  // both memories answer combinationally
  assign idata   = imem[iaddr];
  assign ddata_r = dmem[daddr];

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
  end

  // store lands at the edge that ends the sw cycle
  always @(posedge CLK) begin
    if (RESET_N && d_rw) begin
      dmem[daddr] <= ddata_w;
      check_store();
    end
  end

  // unused words decode as nops, opcode field zero
  task automatic fill_memories();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = 32'(i) << 7;
      dmem[i] = 32'hd000_0000 | 32'(i);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          ch;
    logic        done;
    logic [7:0]  tag;
    logic [31:0] addr;
    logic [31:0] value;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VECTOR_FILE);
      num_errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %c", tag);
        if (code != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          // rest of the line is a comment
          ch = $fgetc(fd);
          while ((ch != 10) && (ch != -1)) begin
            ch = $fgetc(fd);
          end
        end else begin
          code = $fscanf(fd, " %h %h", addr, value);
          if ((code != 2) || (addr >= MEM_WORDS)) begin
            $display("bad vector line with tag %c", tag);
            num_errors++;
          end else if (tag == "P") begin
            imem[addr] = value;
            prog_len++;
          end else if (tag == "D") begin
            dmem[addr] = value;
          end else if ((tag == "E") && (num_expected < MAX_STORES)) begin
            exp_addr[num_expected] = addr[ADDR_WIDTH-1:0];
            exp_data[num_expected] = value;
            num_expected++;
          end else begin
            $display("vector line with tag %c was not used", tag);
            num_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // next store in order against the expected list
  task automatic check_store();
    string name;
    logic  ok;
    name = $sformatf("store_%0d", num_checked);
    ok   = 1'b1;
    if (num_checked < num_expected) begin
      if (daddr !== exp_addr[num_checked]) begin
        $display("FAIL %s address expected 0x%h actual 0x%h", name,
                 exp_addr[num_checked], daddr);
        num_errors++;
        ok = 1'b0;
      end
      if (ddata_w !== exp_data[num_checked]) begin
        $display("FAIL %s data expected 0x%h actual 0x%h", name,
                 exp_data[num_checked], ddata_w);
        num_errors++;
        ok = 1'b0;
      end
      if (ok) begin
        $display("PASS %s word 0x%h data 0x%h", name, daddr, ddata_w);
      end
      num_checked++;
    end
  endtask

  initial begin
    RESET_N = 1'b0;
    fill_memories();
    load_vectors();
    cycle_limit = 4 * prog_len + 20;
    repeat (2) @(posedge CLK);
    #(DRIVE_DELAY);
    RESET_N = 1'b1;
    // wait for all stores or the cycle limit
    while ((num_checked < num_expected) && (cycles < cycle_limit)) begin
      @(negedge CLK);
    end
    if (num_expected == 0) begin
      $display("the vector file holds no expected stores");
      num_errors++;
    end else if (num_checked < num_expected) begin
      $display("run stopped at the cycle limit of %0d with too few stores", cycle_limit);
      num_errors++;
    end
    $display("stores checked %0d of %0d, errors %0d", num_checked, num_expected,
             num_errors);
    if (num_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/rv_pkg.sv
alu/alu.sv
hdl/instr_decoder.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/pc_unit.sv
hdl/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

/* verification/rv_core_vectors.txt */
# columns: tag, word address (hex), word (hex)
# P program word, D data preload, E expected store in order
P 000 40000513  # addi x10, x0, 1024
P 001 FF900093  # addi x1, x0, -7
P 002 06400113  # addi x2, x0, 100
P 003 00152023  # sw x1, 0(x10)
P 004 002081B3  # add x3, x1, x2
P 005 00352223  # sw x3, 4(x10)
P 006 402081B3  # sub
P 007 00352423  # sw x3, 8(x10)
P 008 002091B3  # sll
P 009 00352623  # sw x3, 12(x10)
P 00A 0020A1B3  # slt
P 00B 00352823  # sw x3, 16(x10)
P 00C 0020B1B3  # sltu
P 00D 00352A23  # sw x3, 20(x10)
P 00E 0020C1B3  # xor
P 00F 00352C23  # sw x3, 24(x10)
P 010 0020D1B3  # srl
P 011 00352E23  # sw x3, 28(x10)
P 012 4020D1B3  # sra
P 013 02352023  # sw x3, 32(x10)
P 014 0020E1B3  # or
P 015 02352223  # sw x3, 36(x10)
P 016 0020F1B3  # and
P 017 02352423  # sw x3, 40(x10)
P 018 FFA0A193  # slti x3, x1, -6
P 019 02352623  # sw x3, 44(x10)
P 01A 0050B193  # sltiu x3, x1, 5
P 01B 02352823  # sw x3, 48(x10)
P 01C 0F00C193  # xori x3, x1, 0xf0
P 01D 02352A23  # sw x3, 52(x10)
P 01E F0016193  # ori x3, x2, -256
P 01F 02352C23  # sw x3, 56(x10)
P 020 7F00F193  # andi x3, x1, 0x7f0
P 021 02352E23  # sw x3, 60(x10)
P 022 00809193  # slli x3, x1, 8
P 023 04352023  # sw x3, 64(x10)
P 024 01C0D193  # srli x3, x1, 28
P 025 04352223  # sw x3, 68(x10)
P 026 4020D193  # srai x3, x1, 2
P 027 04352423  # sw x3, 72(x10)
P 028 ABCDE1B7  # lui x3, 0xabcde
P 029 04352623  # sw x3, 76(x10)
P 02A FFFFF197  # auipc x3, 0xfffff at pc 0xa8
P 02B 04352823  # sw x3, 80(x10)
P 02C 24800593  # addi x11, x0, 0x248
P 02D FF85A283  # lw x5, -8(x11)
P 02E FFC5A303  # lw x6, -4(x11)
P 02F 30000613  # addi x12, x0, 0x300
P 030 FE562823  # sw x5, -16(x12)
P 031 FE662A23  # sw x6, -12(x12)
P 032 00208463  # beq x1, x2, +8 not taken
P 033 04252A23  # sw x2, 84(x10)
P 034 00528463  # beq x5, x5, +8 taken
P 035 04152C23  # sw x1, 88(x10) skipped
P 036 00529463  # bne x5, x5, +8 not taken
P 037 04552E23  # sw x5, 92(x10)
P 038 00209463  # bne x1, x2, +8 taken
P 039 06152023  # sw x1, 96(x10) skipped
P 03A 008003EF  # jal x7, +8
P 03B 06152223  # sw x1, 100(x10) skipped
P 03C 06752423  # sw x7, 104(x10)
P 03D 00508013  # addi x0, x1, 5
P 03E 00208033  # add x0, x1, x2
P 03F 06052623  # sw x0, 108(x10)
P 040 0000006F  # jal x0, 0
D 090 CAFEF00D
D 091 12345678
E 100 FFFFFFF9  # addi negative
E 101 0000005D  # add
E 102 FFFFFF95  # sub
E 103 FFFFFF90  # sll by 100 mod 32
E 104 00000001  # slt
E 105 00000000  # sltu
E 106 FFFFFF9D  # xor
E 107 0FFFFFFF  # srl
E 108 FFFFFFFF  # sra
E 109 FFFFFFFD  # or
E 10A 00000060  # and
E 10B 00000001  # slti
E 10C 00000000  # sltiu
E 10D FFFFFF09  # xori
E 10E FFFFFF64  # ori
E 10F 000007F0  # andi
E 110 FFFFF900  # slli
E 111 0000000F  # srli
E 112 FFFFFFFE  # srai
E 113 ABCDE000  # lui
E 114 FFFFF0A8  # auipc
E 0BC CAFEF00D  # lw then sw
E 0BD 12345678  # lw then sw
E 115 00000064  # after beq not taken
E 117 CAFEF00D  # after bne not taken
E 11A 000000EC  # jal link
E 11B 00000000  # x0 after writes
